// ==== compile.f ====
+incdir+include
verilog/io_pkg.sv
verilog/port_decode.sv
verilog/io_check.sv
verilog/io_read_predication.sv
verilog/io_write_predication.sv
verilog/io_ready_control.sv
verilog/io_predication_top.sv
verif/tb_clock_gen.sv
verif/io_predication_tb.sv

// ==== include/io_config.svh ====
//----------------------------------------------------------------------------
// I/O predication configuration
//----------------------------------------------------------------------------

`ifndef IO_CONFIG_SVH
`define IO_CONFIG_SVH

// Width of an operand address as seen by the instruction decoder
`define IO_ADDR_WIDTH 10

// Number of ports in each of the read and write port blocks
`define IO_PORT_COUNT 4

// Low address bits that pick one port inside a block
`define IO_PORT_ADDR_WIDTH 2

// Both blocks sit at the top of the address space, aligned to their size
`define IO_READ_PORT_BASE 10'h3E0
`define IO_WRITE_PORT_BASE 10'h3F0

`endif

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the I/O predication testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f compile.f --top-module io_predication_tb --Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Build failed"
    exit 1
fi

./obj_dir/Vio_predication_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

# The log decides the result
if grep -q "TESTS FAILED" "$LOG"; then
    exit 1
fi
if ! grep -q "TESTS PASSED" "$LOG"; then
    echo "Simulation ended without a result"
    exit 1
fi
exit 0

// ==== verif/io_predication_tb.sv ====
//----------------------------------------------------------------------------
// I/O predication unit testbench
//----------------------------------------------------------------------------

`include "io_config.svh"

module io_predication_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import io_pkg::*;

    localparam int RESET_TIMEOUT = 20;
    localparam int RANDOM_COUNT  = 4000;

    // Expected output levels for one instruction
    typedef struct packed {
        logic       ready;
        port_mask_t rden;
        port_mask_t wren;
        logic       read_is_io;
        logic       write_is_io;
    } expect_t;

    logic clock;
    logic rst;
    logic read_enable;
    addr_t read_addr;
    port_mask_t read_empty_full;
    logic write_enable;
    addr_t write_addr;
    port_mask_t write_empty_full;
    logic io_ready;
    port_mask_t io_rden;
    port_mask_t io_wren;
    logic read_addr_is_io;
    logic write_addr_is_io;

    expect_t pending[$];
    logic [31:0] rand_state;
    int checks;
    int errors;

    tb_clock_gen i_clock_gen (
        .clock (clock),
        .rst   (rst)
    );

    io_predication_top i_dut (
        .clock            (clock),
        .rst              (rst),
        .read_enable      (read_enable),
        .read_addr        (read_addr),
        .read_empty_full  (read_empty_full),
        .write_enable     (write_enable),
        .write_addr       (write_addr),
        .write_empty_full (write_empty_full),
        .io_ready         (io_ready),
        .io_rden          (io_rden),
        .io_wren          (io_wren),
        .read_addr_is_io  (read_addr_is_io),
        .write_addr_is_io (write_addr_is_io)
    );

    //------------------------------------------------------------------------
    // Random numbers and the reference model
    //------------------------------------------------------------------------

    function automatic logic [31:0] next_random();
        rand_state = rand_state * 32'd1664525 + 32'd1013904223;
        return rand_state;
    endfunction

    // Half of the addresses land in the block, a few sit right at its edges
    function automatic addr_t pick_addr(input addr_t base);
        logic [31:0] r;
        r = next_random();
        case (r[31:29])
            3'd0, 3'd1, 3'd2, 3'd3: return base + addr_t'(r[25:24]);
            3'd4:                   return base + addr_t'(`IO_PORT_COUNT);
            3'd5:                   return base - addr_t'(1);
            default:                return r[21:12];
        endcase
    endfunction

    // Window test and flag rules written out directly for each side
    function automatic expect_t model_instruction(
        input logic en_r, input addr_t a_r, input port_mask_t f_r,
        input logic en_w, input addr_t a_w, input port_mask_t f_w
    );
        expect_t     e;
        int          r_off;
        int          w_off;
        port_index_t r_idx;
        port_index_t w_idx;
        logic        r_ok;
        logic        w_ok;
        r_off = int'(a_r) - int'(`IO_READ_PORT_BASE);
        w_off = int'(a_w) - int'(`IO_WRITE_PORT_BASE);
        r_idx = r_off[`IO_PORT_ADDR_WIDTH-1:0];
        w_idx = w_off[`IO_PORT_ADDR_WIDTH-1:0];
        e.read_is_io  = en_r && (r_off >= 0) && (r_off < `IO_PORT_COUNT);
        e.write_is_io = en_w && (w_off >= 0) && (w_off < `IO_PORT_COUNT);
        // Reads need a full port, writes need a port that is not full
        r_ok = !e.read_is_io || (f_r[r_idx] == 1'b1);
        w_ok = !e.write_is_io || (f_w[w_idx] == 1'b0);
        e.ready = r_ok && w_ok;
        e.rden = (e.read_is_io && e.ready) ? (port_mask_t'(1) << r_idx) : '0;
        e.wren = (e.write_is_io && e.ready) ? (port_mask_t'(1) << w_idx) : '0;
        return e;
    endfunction

    //------------------------------------------------------------------------
    // Checking and driving
    //------------------------------------------------------------------------

    task automatic check_field(input string name, input int got, input int want);
        checks++;
        assert (got == want) else begin
            errors++;
            $display("Fail at %0t: %s is %0h, expected %0h", $time, name, got, want);
        end
    endtask

    task automatic compare_outputs(input expect_t want);
        check_field("io_ready", int'(io_ready), int'(want.ready));
        check_field("io_rden", int'(io_rden), int'(want.rden));
        check_field("io_wren", int'(io_wren), int'(want.wren));
        check_field("read_addr_is_io", int'(read_addr_is_io), int'(want.read_is_io));
        check_field("write_addr_is_io", int'(write_addr_is_io), int'(want.write_is_io));
    endtask

    // One instruction per cycle, its result shows two edges after sampling
    task automatic run_cycle(
        input logic en_r, input addr_t a_r, input port_mask_t f_r,
        input logic en_w, input addr_t a_w, input port_mask_t f_w
    );
        expect_t want;
        @(posedge clock);
        read_enable      <= en_r;
        read_addr        <= a_r;
        read_empty_full  <= f_r;
        write_enable     <= en_w;
        write_addr       <= a_w;
        write_empty_full <= f_w;
        pending.push_back(model_instruction(en_r, a_r, f_r, en_w, a_w, f_w));
        // Outputs are settled away from the rising edge
        @(negedge clock);
        if (pending.size() > 2) begin
            want = pending.pop_front();
            compare_outputs(want);
        end
    endtask

    //------------------------------------------------------------------------
    // Test sequence
    //------------------------------------------------------------------------

    initial begin
        int          wait_count;
        logic        timed_out;
        logic [31:0] r;
        logic        en_r;
        logic        en_w;
        addr_t       a_r;
        addr_t       a_w;
        read_enable      = 1'b0;
        read_addr        = '0;
        read_empty_full  = '0;
        write_enable     = 1'b0;
        write_addr       = '0;
        write_empty_full = '0;
        rand_state       = 32'h8168_01f4;
        checks           = 0;
        errors           = 0;
        wait_count       = 0;
        timed_out        = 1'b0;

        do begin
            @(negedge clock);
            wait_count++;
            if (wait_count > RESET_TIMEOUT) begin
                timed_out = 1'b1;
            end
        end while (rst !== 1'b0 && !timed_out);

        if (timed_out) begin
            $display("Timeout: reset still asserted after %0d cycles", RESET_TIMEOUT);
            $display("TESTS FAILED");
            $finish;
        end else begin
            // First result is the cleared pipeline, then the idle inputs
            pending.push_back('0);
            pending.push_back(model_instruction(1'b0, '0, '0, 1'b0, '0, '0));

            // Enables low, then addresses outside or just past both blocks
            run_cycle(1'b0, `IO_READ_PORT_BASE, 4'hF, 1'b0, `IO_WRITE_PORT_BASE, 4'h0);
            run_cycle(1'b1, 10'h010, 4'hF, 1'b1, 10'h155, 4'hF);
            run_cycle(1'b1, 10'h3E4, 4'h0, 1'b1, 10'h3F4, 4'hF);
            // Full read port 2 and free write port 1 both fire
            run_cycle(1'b1, 10'h3E2, 4'b0100, 1'b1, 10'h3F1, 4'b1101);
            // Empty read port annuls a ready write
            run_cycle(1'b1, 10'h3E0, 4'b1110, 1'b1, 10'h3F3, 4'b0000);
            // Full write port annuls a ready read
            run_cycle(1'b1, 10'h3E3, 4'b1000, 1'b1, 10'h3F0, 4'b0001);
            // One side only
            run_cycle(1'b1, 10'h3E1, 4'b0010, 1'b0, 10'h3F2, 4'b0000);
            run_cycle(1'b0, 10'h3E1, 4'b0000, 1'b1, 10'h3F2, 4'b1011);

            // Back to back random instructions
            for (int n = 0; n < RANDOM_COUNT; n++) begin
                r    = next_random();
                en_r = (r[31:29] != 3'd0);
                en_w = (r[28:26] != 3'd0);
                a_r  = pick_addr(`IO_READ_PORT_BASE);
                a_w  = pick_addr(`IO_WRITE_PORT_BASE);
                run_cycle(en_r, a_r, r[23:20], en_w, a_w, r[19:16]);
            end

            // Idle cycles flush the last two instructions
            run_cycle(1'b0, '0, '0, 1'b0, '0, '0);
            run_cycle(1'b0, '0, '0, 1'b0, '0, '0);

            $display("Checks: %0d, errors: %0d", checks, errors);
            if (errors == 0) begin
                $display("TESTS PASSED");
            end else begin
                $display("TESTS FAILED");
            end
            $finish;
        end
    end

endmodule

// ==== verif/tb_clock_gen.sv ====
//----------------------------------------------------------------------------
// Testbench clock and reset
//----------------------------------------------------------------------------

module tb_clock_gen (
    output logic clock,
    output logic rst
);
    timeunit 1ns;
    timeprecision 1ps;

    // Free running clock with an 8 ns period
    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    // Reset covers the first two rising edges and drops on the second one
    initial begin
        rst = 1'b1;
        repeat (2) @(posedge clock);
        rst <= 1'b0;
    end

endmodule

// ==== verilog/io_check.sv ====
//----------------------------------------------------------------------------
// I/O port readiness check
//----------------------------------------------------------------------------

module io_check #(
    parameter io_pkg::addr_t PORT_BASE_ADDR = '0,
    // Flag value that marks a port as ready, 1 (full) for reads
    // and 0 (not full) for writes
    parameter logic          READY_STATE    = 1'b1
) (
    input  logic               clock,
    input  logic               rst,
    input  logic               enable,
    input  io_pkg::addr_t      addr,
    input  io_pkg::port_mask_t empty_full,
    output logic               is_io,
    output logic               port_ready
);
    import io_pkg::*;

    port_mask_t selected;
    logic       is_io_next;
    logic       flag;
    logic       port_ready_next;

    //------------------------------------------------------------------------
    // Stage 1 decode
    //------------------------------------------------------------------------

    port_decode #(
        .PORT_BASE_ADDR (PORT_BASE_ADDR)
    ) i_port_decode (
        .enable         (enable),
        .addr           (addr),
        .active         (selected)
    );

    // Any selected bit means the address hits this port block
    assign is_io_next = |selected;

    // The select is one-hot so the OR picks exactly the addressed flag
    assign flag = |(empty_full & selected);

    // Anything that is not an I/O access never holds up the instruction
    assign port_ready_next = !is_io_next || (flag == READY_STATE);

    //------------------------------------------------------------------------
    // Stage 1 register
    //------------------------------------------------------------------------

    // Ready stays low out of reset so io_ready cannot rise before
    // the first real instruction has been checked
    always_ff @(posedge clock) begin
        if (rst) begin
            is_io      <= 1'b0;
            port_ready <= 1'b0;
        end else begin
            is_io      <= is_io_next;
            port_ready <= port_ready_next;
        end
    end

    // A non-I/O result must always count as ready once real data flows
    // The first cycle after reset still holds the cleared values
    a_not_io_is_ready : assert property (
        @(posedge clock) disable iff (rst)
        (!$past(rst) && !is_io) |-> port_ready
    );

endmodule

// ==== verilog/io_pkg.sv ====
//----------------------------------------------------------------------------
// I/O predication types
//----------------------------------------------------------------------------

`include "io_config.svh"

package io_pkg;

    // Operand or destination address of one instruction
    typedef logic [`IO_ADDR_WIDTH-1:0] addr_t;

    // One bit per port in a block
    // Carries the empty/full flags as well as the read and write enables
    typedef logic [`IO_PORT_COUNT-1:0] port_mask_t;

    // Port number inside a block, taken from the low address bits
    typedef logic [`IO_PORT_ADDR_WIDTH-1:0] port_index_t;

endpackage

// ==== verilog/io_predication_top.sv ====
//----------------------------------------------------------------------------
// I/O predication unit
//----------------------------------------------------------------------------

module io_predication_top (
    input  logic               clock,
    input  logic               rst,
    // Operand side of the instruction
    input  logic               read_enable,
    input  io_pkg::addr_t      read_addr,
    input  io_pkg::port_mask_t read_empty_full,
    // Destination side of the instruction
    input  logic               write_enable,
    input  io_pkg::addr_t      write_addr,
    input  io_pkg::port_mask_t write_empty_full,
    // Results, two cycles behind the sampled inputs
    output logic               io_ready,
    output io_pkg::port_mask_t io_rden,
    output io_pkg::port_mask_t io_wren,
    output logic               read_addr_is_io,
    output logic               write_addr_is_io
);

    logic read_port_ready;
    logic write_port_ready;

    //------------------------------------------------------------------------
    // Read and write sides
    //------------------------------------------------------------------------

    io_read_predication i_read_predication (
        .clock      (clock),
        .rst        (rst),
        .enable     (read_enable),
        .addr       (read_addr),
        .empty_full (read_empty_full),
        .io_ready   (io_ready),
        .port_ready (read_port_ready),
        .io_rden    (io_rden),
        .addr_is_io (read_addr_is_io)
    );

    io_write_predication i_write_predication (
        .clock      (clock),
        .rst        (rst),
        .enable     (write_enable),
        .addr       (write_addr),
        .empty_full (write_empty_full),
        .io_ready   (io_ready),
        .port_ready (write_port_ready),
        .io_wren    (io_wren),
        .addr_is_io (write_addr_is_io)
    );

    // Single decision point fed back into both sides
    io_ready_control i_io_ready_control (
        .clock            (clock),
        .rst              (rst),
        .read_port_ready  (read_port_ready),
        .write_port_ready (write_port_ready),
        .io_ready         (io_ready)
    );

endmodule

// ==== verilog/io_read_predication.sv ====
//----------------------------------------------------------------------------
// Read port predication
//----------------------------------------------------------------------------

`include "io_config.svh"

module io_read_predication (
    input  logic               clock,
    input  logic               rst,
    input  logic               enable,
    input  io_pkg::addr_t      addr,
    input  io_pkg::port_mask_t empty_full,
    input  logic               io_ready,
    output logic               port_ready,
    output io_pkg::port_mask_t io_rden,
    output logic               addr_is_io
);
    import io_pkg::*;

    logic       is_io_raw;
    addr_t      addr_stage_2;
    port_mask_t rden_raw;
    port_mask_t rden_raw_reg;

    // A read port is ready when its FIFO holds data, so the full flag is 1
    io_check #(
        .PORT_BASE_ADDR (`IO_READ_PORT_BASE),
        .READY_STATE    (1'b1)
    ) i_io_check (
        .clock          (clock),
        .rst            (rst),
        .enable         (enable),
        .addr           (addr),
        .empty_full     (empty_full),
        .is_io          (is_io_raw),
        .port_ready     (port_ready)
    );

    //------------------------------------------------------------------------
    // Stage 2 enable decode
    //------------------------------------------------------------------------

    // Hold the address one cycle so it lines up with the check result
    always_ff @(posedge clock) begin
        if (rst) begin
            addr_stage_2 <= '0;
        end else begin
            addr_stage_2 <= addr;
        end
    end

    // The registered is_io gates the decode of the aligned address
    port_decode #(
        .PORT_BASE_ADDR (`IO_READ_PORT_BASE)
    ) i_port_decode (
        .enable         (is_io_raw),
        .addr           (addr_stage_2),
        .active         (rden_raw)
    );

    // The raw enables and the I/O bit wait here for io_ready
    always_ff @(posedge clock) begin
        if (rst) begin
            rden_raw_reg <= '0;
            addr_is_io   <= 1'b0;
        end else begin
            rden_raw_reg <= rden_raw;
            addr_is_io   <= is_io_raw;
        end
    end

    // Annul the read unless every port touched by the instruction is ready
    // A read pops the FIFO, so firing it for a replayed instruction loses data
    assign io_rden = rden_raw_reg & {`IO_PORT_COUNT{io_ready}};

    a_rden_onehot : assert property (
        @(posedge clock) disable iff (rst)
        $onehot0(io_rden)
    );

endmodule

// ==== verilog/io_ready_control.sv ====
//----------------------------------------------------------------------------
// I/O ready control
//----------------------------------------------------------------------------

module io_ready_control (
    input  logic clock,
    input  logic rst,
    input  logic read_port_ready,
    input  logic write_port_ready,
    output logic io_ready
);

    //------------------------------------------------------------------------
    // Instruction readiness
    //------------------------------------------------------------------------

    // The whole instruction goes ahead only when both of its ports are ready
    // The same level gates both sides, so a read and a write are always
    // annulled together and never half done
    always_ff @(posedge clock) begin
        if (rst) begin
            io_ready <= 1'b0;
        end else begin
            io_ready <= read_port_ready & write_port_ready;
        end
    end

    // The pipeline holds no valid instruction right after reset
    a_ready_low_after_reset : assert property (
        @(posedge clock)
        rst |=> !io_ready
    );

endmodule

// ==== verilog/io_write_predication.sv ====
//----------------------------------------------------------------------------
// Write port predication
//----------------------------------------------------------------------------

`include "io_config.svh"

module io_write_predication (
    input  logic               clock,
    input  logic               rst,
    input  logic               enable,
    input  io_pkg::addr_t      addr,
    input  io_pkg::port_mask_t empty_full,
    input  logic               io_ready,
    output logic               port_ready,
    output io_pkg::port_mask_t io_wren,
    output logic               addr_is_io
);
    import io_pkg::*;

    logic       is_io_raw;
    addr_t      addr_stage_2;
    port_mask_t wren_raw;
    port_mask_t wren_raw_reg;

    // A write port is ready while it still has room, so the full flag is 0
    io_check #(
        .PORT_BASE_ADDR (`IO_WRITE_PORT_BASE),
        .READY_STATE    (1'b0)
    ) i_io_check (
        .clock          (clock),
        .rst            (rst),
        .enable         (enable),
        .addr           (addr),
        .empty_full     (empty_full),
        .is_io          (is_io_raw),
        .port_ready     (port_ready)
    );

    //------------------------------------------------------------------------
    // Stage 2 enable decode
    //------------------------------------------------------------------------

    always_ff @(posedge clock) begin
        if (rst) begin
            addr_stage_2 <= '0;
        end else begin
            addr_stage_2 <= addr;
        end
    end

    port_decode #(
        .PORT_BASE_ADDR (`IO_WRITE_PORT_BASE)
    ) i_port_decode (
        .enable         (is_io_raw),
        .addr           (addr_stage_2),
        .active         (wren_raw)
    );

    always_ff @(posedge clock) begin
        if (rst) begin
            wren_raw_reg <= '0;
            addr_is_io   <= 1'b0;
        end else begin
            wren_raw_reg <= wren_raw;
            addr_is_io   <= is_io_raw;
        end
    end

    // A write pushes into the port FIFO, so it is dropped for annulled work
    assign io_wren = wren_raw_reg & {`IO_PORT_COUNT{io_ready}};

    // Any write that leaves must be a ready instruction aimed at a port
    a_wren_predicated : assert property (
        @(posedge clock) disable iff (rst)
        (io_wren != '0) |-> (io_ready && addr_is_io)
    );

endmodule

// ==== verilog/port_decode.sv ====
//----------------------------------------------------------------------------
// Port select decoder
//----------------------------------------------------------------------------

`include "io_config.svh"

module port_decode #(
    parameter io_pkg::addr_t PORT_BASE_ADDR = '0
) (
    input  logic               enable,
    input  io_pkg::addr_t      addr,
    output io_pkg::port_mask_t active
);
    import io_pkg::*;

    addr_t       offset;
    port_index_t index;
    logic        in_window;

    // Addresses below the base wrap to a large offset and fall outside
    assign offset    = addr - PORT_BASE_ADDR;
    assign index     = offset[`IO_PORT_ADDR_WIDTH-1:0];
    assign in_window = (offset < addr_t'(`IO_PORT_COUNT));

    // One-hot select for the addressed port, all zero when not selected
    always_comb begin
        active = '0;
        if (enable && in_window) begin
            active[index] = 1'b1;
        end
    end

endmodule
